/* verilog.f */
+incdir+include
hdl/elevator_pkg.sv
hdl/car_status_decoder.sv
hdl/request_stack.sv
hdl/dispatch_selector.sv
hdl/floor_logic_top.sv
tests/floor_logic_props.sv
tests/floor_logic_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the elevator controller testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module floor_logic_tb -Mdir obj_dir -o floor_logic_sim > build.log 2>&1 &&
./obj_dir/floor_logic_sim > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -qx "sim passed" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }

/* tests/floor_logic_tb.sv */
// Testbench for the elevator floor-request controller
// Directed tests for push, LIFO pop, duplicates, halt and doors,
// one report line per test and a cycle limit

`default_nettype none

`include "elevator_cfg.svh"

module floor_logic_tb;

    import elevator_pkg::*;

    // The tests take under 100 cycles, the limit leaves ample margin
    localparam int CYCLE_LIMIT = 400;

    logic          clock;
    logic          reset_n;
    button_bank_t  buttons;
    logic          door_open_btn;
    logic          door_close_btn;
    logic          emergency_btn;
    logic          power_switch;
    floor_t        current_floor;
    car_state_e    car_state;
    button_bank_t  lights;
    dispatch_cmd_t command;
    logic          door_open_allowed;
    logic          door_close_allowed;

    integer seed;
    int     pick;
    floor_t target;
    int     cycle_count;
    int     test_errors;
    int     pass_count;
    int     fail_count;

    floor_logic_top uut (
        .clock              (clock),
        .reset_n            (reset_n),
        .buttons            (buttons),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .emergency_btn      (emergency_btn),
        .power_switch       (power_switch),
        .current_floor      (current_floor),
        .car_state          (car_state),
        .lights             (lights),
        .command            (command),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    function automatic floor_mask_t one_hot(input floor_t f);
        return floor_mask_t'(1) << f;
    endfunction

    // STOP_FLn is encoded as n-1, the same code as the floor number
    function automatic car_state_e stop_state(input floor_t f);
        return car_state_e'({2'b00, f});
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got == exp) else begin
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic hold_cycle();
        @(posedge clock);
        @(negedge clock);
    endtask

    // One-cycle press, returns after the edge that took it
    task automatic press(input floor_mask_t panel_mask, input floor_mask_t call_mask);
        @(posedge clock);
        buttons.panel <= panel_mask;
        buttons.call  <= call_mask;
        @(posedge clock);
        buttons <= '0;
        @(negedge clock);
    endtask

    task automatic move_car(input car_state_e state, input floor_t f);
        @(posedge clock);
        car_state     <= state;
        current_floor <= f;
        @(negedge clock);
    endtask

    task automatic set_power(input logic emergency, input logic power);
        @(posedge clock);
        emergency_btn <= emergency;
        power_switch  <= power;
        @(negedge clock);
    endtask

    task automatic set_doors(input logic open_btn, input logic close_btn);
        @(posedge clock);
        door_open_btn  <= open_btn;
        door_close_btn <= close_btn;
        @(negedge clock);
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////
    initial begin
        seed           = 32'hf043_f0a2;
        test_errors    = 0;
        pass_count     = 0;
        fail_count     = 0;
        reset_n        = 1'b0;
        buttons        = '0;
        door_open_btn  = 1'b0;
        door_close_btn = 1'b0;
        emergency_btn  = 1'b0;
        power_switch   = 1'b1;
        current_floor  = '0;
        car_state      = STOP_FL1;
        repeat (3) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);

        check_eq(lights, '0, "lights");
        check_eq(command.activate, 1'b0, "activate");
        check_eq(command.up, 1'b0, "up");
        check_eq(command.floor, current_floor, "target");
        end_test("after reset");

        // Random other floor from floor 5, skipping the car's own floor
        move_car(STOP_FL5, 4'd4);
        pick = $unsigned($random(seed)) % (`FLOOR_COUNT - 1);
        if (pick >= 4) begin
            pick++;
        end
        target = floor_t'(pick);
        press(one_hot(target), '0);
        check_eq(lights.panel, one_hot(target), "panel lights");
        check_eq(lights.call, '0, "call lights");
        check_eq(command.floor, target, "target");
        check_eq(command.activate, 1'b1, "activate");
        check_eq(command.up, target > 4'd4, "up");
        move_car(stop_state(target), target);
        hold_cycle();
        check_eq(lights, '0, "lights after arrival");
        check_eq(command.activate, 1'b0, "activate after arrival");
        end_test("push and dispatch");

        move_car(STOP_FL1, 4'd0);
        press(one_hot(4'd2), '0);
        press(one_hot(4'd7), '0);
        check_eq(lights.panel, one_hot(4'd2) | one_hot(4'd7), "panel lights");
        check_eq(command.floor, 4'd7, "target is last pushed");
        check_eq(command.up, 1'b1, "up");
        move_car(STOP_FL8, 4'd7);
        hold_cycle();
        check_eq(lights.panel, one_hot(4'd2), "panel lights after pop");
        check_eq(command.floor, 4'd2, "target after pop");
        check_eq(command.activate, 1'b1, "activate after pop");
        check_eq(command.up, 1'b0, "up after pop");
        // Moving car, heading is held from the last dispatch
        move_car(UP_F8_F9, 4'd7);
        check_eq(command.activate, 1'b0, "activate while moving");
        check_eq(command.up, 1'b0, "held direction");
        move_car(STOP_FL3, 4'd2);
        hold_cycle();
        check_eq(lights, '0, "lights after last pop");
        end_test("lifo order and pop");

        press(one_hot(4'd2), one_hot(4'd2));
        check_eq(lights, '0, "lights for own floor");
        check_eq(command.activate, 1'b0, "activate for own floor");
        press(one_hot(4'd5), '0);
        press('0, one_hot(4'd5));
        check_eq(lights.panel, one_hot(4'd5), "panel lights");
        check_eq(lights.call, '0, "call light of pending floor");
        check_eq(command.floor, 4'd5, "target");
        move_car(STOP_FL6, 4'd5);
        hold_cycle();
        check_eq(lights, '0, "lights after arrival");
        check_eq(command.up, 1'b1, "held direction after arrival");
        end_test("no duplicate");

        // Panel bank wins over a call press in the same cycle
        press(one_hot(4'd9), one_hot(4'd1));
        check_eq(lights.panel, one_hot(4'd9), "panel lights");
        check_eq(lights.call, '0, "call lights");
        set_power(1'b1, 1'b1);
        check_eq(command.activate, 1'b0, "activate in emergency");
        hold_cycle();
        check_eq(lights, '0, "lights after emergency");
        press(one_hot(4'd3), one_hot(4'd8));
        check_eq(lights, '0, "lights for press in emergency");
        set_power(1'b0, 1'b1);
        check_eq(command.activate, 1'b0, "activate after emergency");
        check_eq(command.floor, 4'd5, "target after emergency");
        press(one_hot(4'd0), '0);
        check_eq(lights.panel, one_hot(4'd0), "panel lights");
        set_power(1'b0, 1'b0);
        check_eq(command.activate, 1'b0, "activate after power-off");
        hold_cycle();
        check_eq(lights, '0, "lights after power-off");
        set_power(1'b0, 1'b1);
        end_test("halt");

        set_doors(1'b1, 1'b0);
        check_eq({door_open_allowed, door_close_allowed}, 2'b10, "doors stopped");
        set_doors(1'b0, 1'b1);
        check_eq({door_open_allowed, door_close_allowed}, 2'b01, "doors stopped");
        set_doors(1'b1, 1'b1);
        move_car(UP_F6_F7, 4'd5);
        check_eq({door_open_allowed, door_close_allowed}, 2'b00, "doors moving");
        move_car(STOP_FL6, 4'd5);
        check_eq({door_open_allowed, door_close_allowed}, 2'b11, "doors stopped");
        set_power(1'b0, 1'b0);
        check_eq({door_open_allowed, door_close_allowed}, 2'b00, "doors unpowered");
        set_power(1'b0, 1'b1);
        set_doors(1'b0, 1'b0);
        end_test("doors");

        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/floor_logic_props.sv */
// Concurrent checks on the elevator controller top level
// Activate gating, light clearing on halt, door permission gating

`default_nettype none

module floor_logic_props (
    input wire logic                        clock,
    input wire logic                        reset_n,
    input wire elevator_pkg::car_status_t   status,
    input wire elevator_pkg::button_bank_t  lights,
    input wire elevator_pkg::dispatch_cmd_t command,
    input wire logic                        door_open_allowed,
    input wire logic                        door_close_allowed
);

    // The car is only sent off while standing and powered
    activate_needs_stop: assert property (
        @(posedge clock) disable iff (!reset_n)
        command.activate |-> (status.stopped && !status.halted)
    ) else $error("activate raised while the car was moving or halted");

    // A halt drops every light at the following edge
    halt_clears_lights: assert property (
        @(posedge clock) disable iff (!reset_n)
        status.halted |=> (lights == '0)
    ) else $error("lights still lit one cycle after a halt");

    doors_need_stop: assert property (
        @(posedge clock) disable iff (!reset_n)
        (door_open_allowed || door_close_allowed) |-> status.stopped
    ) else $error("door permission given while the car was not stopped");

endmodule

bind floor_logic_top floor_logic_props u_props (
    .clock              (clock),
    .reset_n            (reset_n),
    .status             (status),
    .lights             (lights),
    .command            (command),
    .door_open_allowed  (door_open_allowed),
    .door_close_allowed (door_close_allowed)
);

`default_nettype wire

/* hdl/floor_logic_top.sv */
// Elevator floor-request controller, top level
// Status decoder, request stack and dispatch selector

`default_nettype none

module floor_logic_top (
    input  wire logic                       clock,
    input  wire logic                       reset_n,
    input  wire elevator_pkg::button_bank_t buttons,
    input  wire logic                       door_open_btn,
    input  wire logic                       door_close_btn,
    input  wire logic                       emergency_btn,
    input  wire logic                       power_switch,
    input  wire elevator_pkg::floor_t       current_floor,
    input  wire elevator_pkg::car_state_e   car_state,
    output elevator_pkg::button_bank_t      lights,
    output elevator_pkg::dispatch_cmd_t     command,
    output logic                            door_open_allowed,
    output logic                            door_close_allowed
);

    import elevator_pkg::*;

    car_status_t status;
    stack_view_t view;

    car_status_decoder u_status (
        .car_state          (car_state),
        .power_switch       (power_switch),
        .emergency_btn      (emergency_btn),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .status             (status),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    request_stack u_stack (
        .clock         (clock),
        .reset_n       (reset_n),
        .buttons       (buttons),
        .current_floor (current_floor),
        .status        (status),
        .lights        (lights),
        .view          (view)
    );

    dispatch_selector u_dispatch (
        .clock         (clock),
        .reset_n       (reset_n),
        .view          (view),
        .status        (status),
        .current_floor (current_floor),
        .command       (command)
    );

endmodule

`default_nettype wire

/* hdl/dispatch_selector.sv */
// Dispatch selector
// Target floor, direction and activate command from the stack top,
// with a register that holds the last chosen direction

`default_nettype none

module dispatch_selector (
    input  wire logic                      clock,
    input  wire logic                      reset_n,
    input  wire elevator_pkg::stack_view_t view,
    input  wire elevator_pkg::car_status_t status,
    input  wire elevator_pkg::floor_t      current_floor,
    output elevator_pkg::dispatch_cmd_t    command
);

    logic serve;
    logic last_up;

    // A pending floor is acted on only while the car is stopped and live
    assign serve = status.stopped && !status.halted && !view.empty;

    assign command.floor    = serve ? view.top : current_floor;
    assign command.activate = serve && (view.top != current_floor);

    // New heading while moving off, otherwise the remembered one
    assign command.up = command.activate ? (view.top > current_floor) : last_up;

    ////////////////////////////////////////////////////////////
    // Direction memory
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            last_up <= 1'b0;
        end else if (command.activate) begin
            last_up <= command.up;
        end
    end

endmodule

`default_nettype wire

/* hdl/request_stack.sv */
// Request stack for the elevator controller
// Latches panel and call presses into lights, keeps pending floors
// in a LIFO, pops the top floor once the car stands there

`default_nettype none

`include "elevator_cfg.svh"

module request_stack (
    input  wire logic                       clock,
    input  wire logic                       reset_n,
    input  wire elevator_pkg::button_bank_t buttons,
    input  wire elevator_pkg::floor_t       current_floor,
    input  wire elevator_pkg::car_status_t  status,
    output elevator_pkg::button_bank_t      lights,
    output elevator_pkg::stack_view_t       view
);

    import elevator_pkg::*;

    // Enough bits to count from empty up to a full stack
    localparam int PTR_BITS = $clog2(`FLOOR_COUNT + 1);

    floor_t              stack_mem [`FLOOR_COUNT];
    logic [PTR_BITS-1:0] stack_ptr;
    logic [PTR_BITS-1:0] top_idx;
    logic [PTR_BITS-1:0] push_idx;

    floor_mask_t here_mask;
    floor_mask_t busy_mask;
    floor_mask_t panel_req;
    floor_mask_t call_req;
    floor_mask_t push_mask;
    floor_mask_t pop_clear;
    floor_mask_t set_panel;
    floor_mask_t set_call;

    logic   push_valid;
    logic   push_panel;
    floor_t push_floor;
    logic   do_push;
    logic   do_pop;

    ////////////////////////////////////////////////////////////
    // Stack top
    ////////////////////////////////////////////////////////////
    assign top_idx    = stack_ptr - 1'b1;
    assign view.empty = (stack_ptr == '0);
    assign view.top   = view.empty ? '0 : stack_mem[top_idx];

    ////////////////////////////////////////////////////////////
    // New request selection
    ////////////////////////////////////////////////////////////

    // A floor already lit in either bank, or the car's own floor, is not taken
    assign here_mask = floor_mask_t'(1) << current_floor;
    assign busy_mask = lights.panel | lights.call;
    assign panel_req = buttons.panel & ~busy_mask & ~here_mask;
    assign call_req  = buttons.call & ~busy_mask & ~here_mask;

    // Scan downwards so the lowest floor is written last,
    // and the panel bank after the call bank so it wins
    always_comb begin
        push_valid = 1'b0;
        push_panel = 1'b0;
        push_floor = '0;
        for (int i = `FLOOR_COUNT - 1; i >= 0; i--) begin
            if (call_req[i]) begin
                push_valid = 1'b1;
                push_panel = 1'b0;
                push_floor = floor_t'(i);
            end
        end
        for (int i = `FLOOR_COUNT - 1; i >= 0; i--) begin
            if (panel_req[i]) begin
                push_valid = 1'b1;
                push_panel = 1'b1;
                push_floor = floor_t'(i);
            end
        end
    end

    assign do_push = push_valid && !status.halted;

    // Served once the car is stopped at the floor on top
    assign do_pop = status.stopped && !status.halted && !view.empty &&
                    (view.top == current_floor);

    // On push with pop the new floor reuses the freed slot
    assign push_idx = do_pop ? top_idx : stack_ptr;

    assign push_mask = floor_mask_t'(1) << push_floor;
    assign pop_clear = do_pop ? (floor_mask_t'(1) << view.top) : '0;
    assign set_panel = (do_push && push_panel) ? push_mask : '0;
    assign set_call  = (do_push && !push_panel) ? push_mask : '0;

    ////////////////////////////////////////////////////////////
    // Pointer and lights
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            stack_ptr <= '0;
            lights    <= '0;
        end else if (status.halted) begin
            // Power-off or emergency drops every pending request
            stack_ptr <= '0;
            lights    <= '0;
        end else begin
            lights.panel <= (lights.panel & ~pop_clear) | set_panel;
            lights.call  <= (lights.call & ~pop_clear) | set_call;
            if (do_push && !do_pop) begin
                stack_ptr <= stack_ptr + 1'b1;
            end else if (do_pop && !do_push) begin
                stack_ptr <= stack_ptr - 1'b1;
            end
        end
    end

    // Entry storage
    always_ff @(posedge clock) begin
        if (do_push) begin
            stack_mem[push_idx] <= push_floor;
        end
    end

endmodule

`default_nettype wire

/* hdl/car_status_decoder.sv */
// Car status decoder
// Stop-state and halt detection, door open and close permissions

`default_nettype none

module car_status_decoder (
    input  wire elevator_pkg::car_state_e  car_state,
    input  wire logic                      power_switch,
    input  wire logic                      emergency_btn,
    input  wire logic                      door_open_btn,
    input  wire logic                      door_close_btn,
    output elevator_pkg::car_status_t      status,
    output logic                           door_open_allowed,
    output logic                           door_close_allowed
);

    import elevator_pkg::*;

    logic doors_enabled;

    // STOP states occupy the lowest codes
    assign status.stopped = (car_state <= STOP_FL11);

    // No dispatching without power or during an emergency stop
    assign status.halted = !power_switch || emergency_btn;

    ////////////////////////////////////////////////////////////
    // Doors
    ////////////////////////////////////////////////////////////

    // Doors only move with the car standing and powered
    assign doors_enabled = status.stopped && power_switch;

    assign door_open_allowed  = doors_enabled && door_open_btn;
    assign door_close_allowed = doors_enabled && door_close_btn;

endmodule

`default_nettype wire

/* hdl/elevator_pkg.sv */
// Shared types for the elevator floor-request controller
// Floor number and mask types, car state enum, packed bus structs

`default_nettype none

`include "elevator_cfg.svh"

package elevator_pkg;

    // Floor 1 is 0, floor 11 is 10
    typedef logic [`FLOOR_BITS-1:0] floor_t;

    // One bit per floor, bit 0 is floor 1
    typedef logic [`FLOOR_COUNT-1:0] floor_mask_t;

    ////////////////////////////////////////////////////////////
    // Car controller states
    ////////////////////////////////////////////////////////////
    typedef enum logic [`CAR_STATE_BITS-1:0] {
        STOP_FL1     = 6'd0,
        STOP_FL2     = 6'd1,
        STOP_FL3     = 6'd2,
        STOP_FL4     = 6'd3,
        STOP_FL5     = 6'd4,
        STOP_FL6     = 6'd5,
        STOP_FL7     = 6'd6,
        STOP_FL8     = 6'd7,
        STOP_FL9     = 6'd8,
        STOP_FL10    = 6'd9,
        STOP_FL11    = 6'd10,
        UP_F1_F2     = 6'd11,
        UP_F2_F3     = 6'd12,
        UP_F3_F4     = 6'd13,
        UP_F4_F5     = 6'd14,
        UP_F5_F6     = 6'd15,
        UP_F6_F7     = 6'd16,
        UP_F7_F8     = 6'd17,
        UP_F8_F9     = 6'd18,
        UP_F9_F10    = 6'd19,
        UP_F10_F11   = 6'd20,
        DOWN_F11_F10 = 6'd21,
        DOWN_F10_F9  = 6'd22,
        DOWN_F9_F8   = 6'd23,
        DOWN_F8_F7   = 6'd24,
        DOWN_F7_F6   = 6'd25,
        DOWN_F6_F5   = 6'd26,
        DOWN_F5_F4   = 6'd27,
        DOWN_F4_F3   = 6'd28,
        DOWN_F3_F2   = 6'd29,
        DOWN_F2_F1   = 6'd30,
        EMERGENCY    = 6'd31
    } car_state_e;

    ////////////////////////////////////////////////////////////
    // Buses between the blocks
    ////////////////////////////////////////////////////////////

    // Car panel and hall call banks, used for buttons and lights
    typedef struct packed {
        floor_mask_t panel;
        floor_mask_t call;
    } button_bank_t;

    typedef struct packed {
        logic stopped;
        logic halted;
    } car_status_t;

    // Top of the pending-floor LIFO
    typedef struct packed {
        floor_t top;
        logic   empty;
    } stack_view_t;

    // Command to the car controller
    typedef struct packed {
        floor_t floor;
        logic   up;
        logic   activate;
    } dispatch_cmd_t;

endpackage

`default_nettype wire

/* include/elevator_cfg.svh */
// Build-time sizes for the elevator floor-request controller
// Floor count, floor number width and car state code width

`ifndef ELEVATOR_CFG_SVH
`define ELEVATOR_CFG_SVH

// Number of floors served by the car
`define FLOOR_COUNT 11

// Width of a floor number, floor 1 is encoded as 0
`define FLOOR_BITS 4

// Width of the car controller state code
`define CAR_STATE_BITS 6

`endif
